//--- hdl/tcp_mem_pkg.sv
`default_nettype none

package tcp_mem_pkg;

  // memory side of the tx read path
  localparam int mem_data_w = 512;                  // one ddr read beat
  localparam int mem_keep_w = mem_data_w / 8;       // byte enables per beat

  // network side
  localparam int net_data_w = 64;                   // one network word
  localparam int net_keep_w = net_data_w / 8;       // byte enables per word
  localparam int words_per_beat = mem_data_w / net_data_w; // lane groups per beat
  localparam int lane_w = $clog2(words_per_beat);   // lane index width

  // read command word from the offload engine
  localparam int cmd_w = 72;
  localparam int cmd_tag_w = 8;                     // upper byte, not decoded
  localparam int cmd_addr_w = 32;                   // buffer address field
  localparam int cmd_len_w = 23;                    // byte length field
  localparam int cmd_spare_w = cmd_w - cmd_tag_w - cmd_addr_w - cmd_len_w; // 9 unused bits

  // decoded memory command
  localparam int mem_addr_w = 64;                   // zero extended address
  localparam int mem_len_w = 32;                    // zero extended length

  // debug counters and fill level
  localparam int cnt_w = 16;

  // tx word buffer
  localparam int tx_fifo_depth = 32;                // words, power of two
  localparam int fifo_ptr_w = $clog2(tx_fifo_depth);

  // same 72 bits, seen raw or split into fields
  // addr sits at 63:32 and len at 22:0
  typedef union packed {
    logic [cmd_w-1:0] raw;                          // as driven on the stream
    struct packed {
      logic [cmd_tag_w-1:0]   tag;                  // 71:64
      logic [cmd_addr_w-1:0]  addr;                 // 63:32
      logic [cmd_spare_w-1:0] spare;                // 31:23
      logic [cmd_len_w-1:0]   len;                  // 22:0
    } fld;
  } mem_cmd_u;

endpackage

`default_nettype wire

//--- hdl/mem_cmd_formatter.sv
`default_nettype none

module mem_cmd_formatter (
  input  wire                                   net_clk,
  input  wire                                   net_aresetn,
  // command stream from the offload engine
  input  wire tcp_mem_pkg::mem_cmd_u            cmd_word,
  input  wire                                   cmd_valid,
  output logic                                  cmd_ready,
  // decoded read command towards memory
  output logic [tcp_mem_pkg::mem_addr_w-1:0]    mem_rd_addr,
  output logic [tcp_mem_pkg::mem_len_w-1:0]     mem_rd_len,
  output logic                                  mem_rd_valid,
  input  wire                                   mem_rd_ready,
  // debug
  output logic [tcp_mem_pkg::cnt_w-1:0]         read_cmd_count
);

  tcp_mem_pkg::mem_cmd_u cmd_q;                     // held command word
  logic                  full_q;                    // slice occupied
  logic                  cmd_take;                  // input handshake
  logic                  rd_take;                   // output handshake

  // one entry slice, refill in the same cycle the entry leaves
  assign cmd_ready = ~full_q | mem_rd_ready;
  assign cmd_take  = cmd_valid & cmd_ready;
  assign rd_take   = full_q & mem_rd_ready;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      full_q <= 1'b0;
    end else if (cmd_take) begin
      full_q <= 1'b1;                               // new entry, maybe back to back
    end else if (rd_take) begin
      full_q <= 1'b0;                               // drained
    end
  end

  // payload only, no reset
  always_ff @(posedge net_clk) begin
    if (cmd_take) begin
      cmd_q.raw <= cmd_word.raw;
    end
  end

  // address from bits 63:32, upper half zero
  assign mem_rd_addr = {{(tcp_mem_pkg::mem_addr_w - tcp_mem_pkg::cmd_addr_w){1'b0}},
                        cmd_q.fld.addr};
  // length from bits 22:0, zero extended
  assign mem_rd_len  = {{(tcp_mem_pkg::mem_len_w - tcp_mem_pkg::cmd_len_w){1'b0}},
                        cmd_q.fld.len};
  assign mem_rd_valid = full_q;

  // commands taken by memory
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      read_cmd_count <= '0;
    end else if (rd_take) begin
      read_cmd_count <= read_cmd_count + 1'b1;      // wraps at 16 bits
    end
  end

endmodule

`default_nettype wire

//--- hdl/mem_width_downsizer.sv
`default_nettype none

module mem_width_downsizer (
  input  wire                                   net_clk,
  input  wire                                   net_aresetn,
  // wide beats from memory
  input  wire [tcp_mem_pkg::mem_data_w-1:0]     mem_data,
  input  wire [tcp_mem_pkg::mem_keep_w-1:0]     mem_keep,
  input  wire                                   mem_last,
  input  wire                                   mem_valid,
  output logic                                  mem_ready,
  // narrow words towards the tx fifo
  output logic [tcp_mem_pkg::net_data_w-1:0]    word_data,
  output logic [tcp_mem_pkg::net_keep_w-1:0]    word_keep,
  output logic                                  word_last,
  output logic                                  word_valid,
  input  wire                                   word_ready,
  // debug
  output logic [tcp_mem_pkg::cnt_w-1:0]         read_pkg_count
);

  logic [tcp_mem_pkg::mem_data_w-1:0]   data_q;    // held beat
  logic [tcp_mem_pkg::mem_keep_w-1:0]   keep_q;
  logic                                 last_q;    // beat closes a package
  logic                                 full_q;    // beat held
  logic [tcp_mem_pkg::lane_w-1:0]       lane_q;    // group being emitted
  logic [tcp_mem_pkg::lane_w:0]         lane_nxt;  // one wider, reaches words_per_beat
  logic [tcp_mem_pkg::words_per_beat:0] grp_nz;    // top bit stays zero
  logic                                 lane_final;
  logic                                 beat_take;
  logic                                 word_take;

  // group i is live when any of its 8 keep bits is set
  always_comb begin
    grp_nz = '0;
    for (int g = 0; g < tcp_mem_pkg::words_per_beat; g++) begin
      grp_nz[g] = |keep_q[g*tcp_mem_pkg::net_keep_w +: tcp_mem_pkg::net_keep_w];
    end
  end

  // keep is contiguous, so the first dead group ends the beat
  assign lane_nxt   = {1'b0, lane_q} + 1'b1;
  assign lane_final = ~grp_nz[lane_nxt];          // also true past group 7

  assign word_valid = full_q;
  assign word_take  = full_q & word_ready;
  // refill while the last word of the held beat leaves
  assign mem_ready  = ~full_q | (word_ready & lane_final);
  assign beat_take  = mem_valid & mem_ready;

  assign word_data = data_q[lane_q*tcp_mem_pkg::net_data_w +: tcp_mem_pkg::net_data_w];
  assign word_keep = keep_q[lane_q*tcp_mem_pkg::net_keep_w +: tcp_mem_pkg::net_keep_w];
  assign word_last = last_q & lane_final;          // only on the closing word

  // control
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      full_q <= 1'b0;
      lane_q <= '0;
    end else begin
      if (beat_take) begin
        full_q <= 1'b1;
        lane_q <= '0;                               // restart at group 0
      end else if (word_take) begin
        if (lane_final) begin
          full_q <= 1'b0;                           // beat used up
          lane_q <= '0;
        end else begin
          lane_q <= lane_q + 1'b1;                  // step to next group
        end
      end
    end
  end

  // beat payload, no reset
  always_ff @(posedge net_clk) begin
    if (beat_take) begin
      data_q <= mem_data;
      keep_q <= mem_keep;
      last_q <= mem_last;
    end
  end

  // beats accepted with last set
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      read_pkg_count <= '0;
    end else if (beat_take && mem_last) begin
      read_pkg_count <= read_pkg_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/net_tx_fifo.sv
`default_nettype none

module net_tx_fifo (
  input  wire                                   net_clk,
  input  wire                                   net_aresetn,
  // write side, from the downsizer
  input  wire [tcp_mem_pkg::net_data_w-1:0]     word_data,
  input  wire [tcp_mem_pkg::net_keep_w-1:0]     word_keep,
  input  wire                                   word_last,
  input  wire                                   word_valid,
  output logic                                  word_ready,
  // read side, network tx port
  output logic [tcp_mem_pkg::net_data_w-1:0]    net_data,
  output logic [tcp_mem_pkg::net_keep_w-1:0]    net_keep,
  output logic                                  net_last,
  output logic                                  net_valid,
  input  wire                                   net_ready,
  // write side fill level, two cycles late
  output logic [tcp_mem_pkg::cnt_w-1:0]         tx_buffer_count
);

  // storage, split by field
  logic [tcp_mem_pkg::net_data_w-1:0] data_ram [tcp_mem_pkg::tx_fifo_depth];
  logic [tcp_mem_pkg::net_keep_w-1:0] keep_ram [tcp_mem_pkg::tx_fifo_depth];
  logic                               last_ram [tcp_mem_pkg::tx_fifo_depth];

  logic [tcp_mem_pkg::fifo_ptr_w-1:0] wr_ptr_q;     // wraps at depth
  logic [tcp_mem_pkg::fifo_ptr_w-1:0] rd_ptr_q;
  logic [tcp_mem_pkg::fifo_ptr_w:0]   fill_q;       // 0 .. depth
  logic [tcp_mem_pkg::cnt_w-1:0]      fill_ext;
  logic [tcp_mem_pkg::cnt_w-1:0]      count_q1;     // first count stage
  logic                               wr_en;
  logic                               rd_en;

  assign word_ready = (fill_q != tcp_mem_pkg::tx_fifo_depth);
  assign net_valid  = (fill_q != '0);
  assign wr_en      = word_valid & word_ready;
  assign rd_en      = net_valid & net_ready;

  // head of queue shows without a read cycle
  assign net_data = data_ram[rd_ptr_q];
  assign net_keep = keep_ram[rd_ptr_q];
  assign net_last = last_ram[rd_ptr_q];

  always_ff @(posedge net_clk) begin
    if (wr_en) begin
      data_ram[wr_ptr_q] <= word_data;
      keep_ram[wr_ptr_q] <= word_keep;
      last_ram[wr_ptr_q] <= word_last;
    end
  end

  // pointers and fill level
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;                  // both or neither
      endcase
    end
  end

  // widen to the debug width
  assign fill_ext = {{(tcp_mem_pkg::cnt_w - tcp_mem_pkg::fifo_ptr_w - 1){1'b0}}, fill_q};

  // two register stages on the count
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      count_q1        <= '0;
      tx_buffer_count <= '0;
    end else begin
      count_q1        <= fill_ext;
      tx_buffer_count <= count_q1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/tcp_tx_mem_path.sv
`default_nettype none

module tcp_tx_mem_path (
  input  wire                                   net_clk,
  input  wire                                   net_aresetn,
  // read commands from the offload engine
  input  wire tcp_mem_pkg::mem_cmd_u            cmd_word,
  input  wire                                   cmd_valid,
  output logic                                  cmd_ready,
  // memory read command
  output logic [tcp_mem_pkg::mem_addr_w-1:0]    mem_rd_addr,
  output logic [tcp_mem_pkg::mem_len_w-1:0]     mem_rd_len,
  output logic                                  mem_rd_valid,
  input  wire                                   mem_rd_ready,
  // memory read data
  input  wire [tcp_mem_pkg::mem_data_w-1:0]     mem_data,
  input  wire [tcp_mem_pkg::mem_keep_w-1:0]     mem_keep,
  input  wire                                   mem_last,
  input  wire                                   mem_valid,
  output logic                                  mem_ready,
  // network tx words
  output logic [tcp_mem_pkg::net_data_w-1:0]    net_data,
  output logic [tcp_mem_pkg::net_keep_w-1:0]    net_keep,
  output logic                                  net_last,
  output logic                                  net_valid,
  input  wire                                   net_ready,
  // debug
  output logic [tcp_mem_pkg::cnt_w-1:0]         read_cmd_count,
  output logic [tcp_mem_pkg::cnt_w-1:0]         read_pkg_count,
  output logic [tcp_mem_pkg::cnt_w-1:0]         tx_buffer_count
);

  // downsizer to fifo
  logic [tcp_mem_pkg::net_data_w-1:0] word_data;
  logic [tcp_mem_pkg::net_keep_w-1:0] word_keep;
  logic                               word_last;
  logic                               word_valid;
  logic                               word_ready;

  // command slice and decode
  mem_cmd_formatter cmd_fmt (
    .net_clk        (net_clk),
    .net_aresetn    (net_aresetn),
    .cmd_word       (cmd_word),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .mem_rd_addr    (mem_rd_addr),
    .mem_rd_len     (mem_rd_len),
    .mem_rd_valid   (mem_rd_valid),
    .mem_rd_ready   (mem_rd_ready),
    .read_cmd_count (read_cmd_count)
  );

  // 512 to 64 bit
  mem_width_downsizer tx_downsizer (
    .net_clk        (net_clk),
    .net_aresetn    (net_aresetn),
    .mem_data       (mem_data),
    .mem_keep       (mem_keep),
    .mem_last       (mem_last),
    .mem_valid      (mem_valid),
    .mem_ready      (mem_ready),
    .word_data      (word_data),
    .word_keep      (word_keep),
    .word_last      (word_last),
    .word_valid     (word_valid),
    .word_ready     (word_ready),
    .read_pkg_count (read_pkg_count)
  );

  // word buffer in front of the network port
  net_tx_fifo tx_fifo (
    .net_clk         (net_clk),
    .net_aresetn     (net_aresetn),
    .word_data       (word_data),
    .word_keep       (word_keep),
    .word_last       (word_last),
    .word_valid      (word_valid),
    .word_ready      (word_ready),
    .net_data        (net_data),
    .net_keep        (net_keep),
    .net_last        (net_last),
    .net_valid       (net_valid),
    .net_ready       (net_ready),
    .tx_buffer_count (tx_buffer_count)
  );

endmodule

`default_nettype wire

//--- test/tcp_tx_mem_path_props.sv
`default_nettype none

module tcp_tx_mem_path_props (
  input logic                                 net_clk,
  input logic                                 net_aresetn,
  input logic [tcp_mem_pkg::cmd_w-1:0]        cmd_word,
  input logic                                 cmd_valid,
  input logic                                 cmd_ready,
  input logic [tcp_mem_pkg::mem_addr_w-1:0]   mem_rd_addr,
  input logic [tcp_mem_pkg::mem_len_w-1:0]    mem_rd_len,
  input logic                                 mem_rd_valid,
  input logic                                 mem_rd_ready,
  input logic [tcp_mem_pkg::net_data_w-1:0]   net_data,
  input logic [tcp_mem_pkg::net_keep_w-1:0]   net_keep,
  input logic                                 net_last,
  input logic                                 net_valid,
  input logic                                 net_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  int prop_fails = 0;                               // read by the testbench summary

  // stalled command holds its word
  cmd_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_word))
    else begin
      $error("command stream changed while stalled");
      prop_fails++;
    end

  // decoded read command holds under back-pressure
  rd_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    mem_rd_valid && !mem_rd_ready |=> mem_rd_valid && $stable({mem_rd_addr, mem_rd_len}))
    else begin
      $error("memory read command changed while stalled");
      prop_fails++;
    end

  // network word stays put until taken
  net_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    net_valid && !net_ready |=> net_valid && $stable({net_data, net_keep, net_last}))
    else begin
      $error("network word changed while stalled");
      prop_fails++;
    end

  // empty slice always takes a command
  idle_ready: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    !mem_rd_valid |-> cmd_ready)
    else begin
      $error("cmd_ready low with the command slice empty");
      prop_fails++;
    end

endmodule

bind tcp_tx_mem_path tcp_tx_mem_path_props stream_props (
  .net_clk(net_clk), .net_aresetn(net_aresetn),
  .cmd_word(cmd_word), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
  .mem_rd_addr(mem_rd_addr), .mem_rd_len(mem_rd_len),
  .mem_rd_valid(mem_rd_valid), .mem_rd_ready(mem_rd_ready),
  .net_data(net_data), .net_keep(net_keep), .net_last(net_last),
  .net_valid(net_valid), .net_ready(net_ready)
);

`default_nettype wire

//--- test/tcp_tx_mem_path_tb.sv
`default_nettype none

module tcp_tx_mem_path_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic                                  net_clk = 1'b0;
  logic                                  net_aresetn = 1'b0;
  tcp_mem_pkg::mem_cmd_u                 cmd_word = '0;
  logic                                  cmd_valid = 1'b0;
  logic                                  cmd_ready;
  logic [tcp_mem_pkg::mem_addr_w-1:0]    mem_rd_addr;
  logic [tcp_mem_pkg::mem_len_w-1:0]     mem_rd_len;
  logic                                  mem_rd_valid;
  logic                                  mem_rd_ready = 1'b0;
  logic [tcp_mem_pkg::mem_data_w-1:0]    mem_data = '0;
  logic [tcp_mem_pkg::mem_keep_w-1:0]    mem_keep = '0;
  logic                                  mem_last = 1'b0;
  logic                                  mem_valid = 1'b0;
  logic                                  mem_ready;
  logic [tcp_mem_pkg::net_data_w-1:0]    net_data;
  logic [tcp_mem_pkg::net_keep_w-1:0]    net_keep;
  logic                                  net_last;
  logic                                  net_valid;
  logic                                  net_ready = 1'b0;
  logic [tcp_mem_pkg::cnt_w-1:0]         read_cmd_count;
  logic [tcp_mem_pkg::cnt_w-1:0]         read_pkg_count;
  logic [tcp_mem_pkg::cnt_w-1:0]         tx_buffer_count;

  // stimulus table: command word, beat keep, beat last, lane data seed
  logic [71:0] tab_cmd [12] = '{
    72'hA5_0000_1000_0000_05DC, 72'h3C_DEAD_BEEF_FF80_0040, 72'h00_FFFF_FFFF_007F_FFFF,
    72'hFF_0000_0001_8000_0001, 72'h11_1234_5678_0000_0200, 72'h22_8000_0000_0040_0000,
    72'h5A_0BAD_F00D_7FFF_FFFF, 72'h01_0000_0000_0000_0000, 72'hC3_CAFE_0000_0012_3456,
    72'h7E_0000_FFFF_FFFF_FFFF, 72'h96_4000_2000_0000_1000, 72'hE1_ABCD_EF01_2345_6789};
  logic [63:0] tab_keep [12] = '{
    64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0000_0000_00FF,
    64'h0000_0000_00FF_FFFF, 64'h0000_0000_0000_000F, 64'h0000_00FF_FFFF_FFFF,
    64'h0FFF_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0001, 64'h0000_0000_FFFF_FFFF,
    64'h0000_0000_07FF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 64'h00FF_FFFF_FFFF_FFFF};
  logic        tab_last [12] = '{0, 1, 1, 0, 1, 1, 0, 1, 0, 1, 0, 1};
  logic [63:0] tab_seed [12] = '{
    64'h1000_0000_0000_0000, 64'h2000_0000_0000_0100, 64'h3000_0000_0000_0200,
    64'h4000_0000_0000_0300, 64'h5000_0000_0000_0400, 64'h6000_0000_0000_0500,
    64'h7000_0000_0000_0600, 64'h8000_0000_0000_0700, 64'h9000_0000_0000_0800,
    64'hA000_0000_0000_0900, 64'hB000_0000_0000_0A00, 64'hC000_0000_0000_0B00};

  integer      seed = 68890;                        // for net_ready and mem_rd_ready
  int          cyc = 0;                             // posedge count
  int          mism_errs = 0;
  int          other_errs = 0;
  int          cmds_sent = 0;
  int          pkgs_sent = 0;
  logic        hold_net = 1'b0;                     // forces net_ready low
  logic [63:0] exp_data_q [$];                      // scoreboard, net words in order
  logic [7:0]  exp_keep_q [$];
  logic        exp_last_q [$];
  logic [63:0] exp_addr_q [$];                      // pending read commands
  logic [31:0] exp_len_q [$];
  int          exp_cyc_q [$];                       // cycle the command must show up

  tcp_tx_mem_path DUT (.*);

  always #20 net_clk = ~net_clk;                    // 40 ns period

  always @(posedge net_clk) cyc <= cyc + 1;

  // ready inputs, changed just after the edge
  always @(posedge net_clk) begin
    #2;
    mem_rd_ready = ($random(seed) & 3) != 0;
    net_ready    = hold_net ? 1'b0 : (($random(seed) & 3) != 0);
  end

  task automatic show_value_error(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
    mism_errs++;
    $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
  endtask

  task automatic send_cmd(input logic [71:0] raw);
    cmd_word.raw = raw;
    cmd_valid    = 1'b1;
    do @(negedge net_clk); while (!cmd_ready);      // taken on the coming edge
    cmds_sent++;
    @(posedge net_clk);
    #2 cmd_valid = 1'b0;
  endtask

  // beat with lane g = seed + g * 0x0101..., one word per live keep group
  task automatic send_beat(input logic [63:0] keep, input logic last, input logic [63:0] dseed);
    logic [511:0] beat;
    int           n_live;
    n_live = 0;
    for (int g = 0; g < 8; g++) begin
      beat[g*64 +: 64] = dseed + g * 64'h0101_0101_0101_0101;
      if (keep[g*8 +: 8] != 8'h00) n_live = g + 1;  // keep is contiguous
    end
    for (int g = 0; g < n_live; g++) begin
      exp_data_q.push_back(beat[g*64 +: 64]);
      exp_keep_q.push_back(keep[g*8 +: 8]);
      exp_last_q.push_back(last && (g == n_live - 1));
    end
    mem_data  = beat;
    mem_keep  = keep;
    mem_last  = last;
    mem_valid = 1'b1;
    do @(negedge net_clk); while (!mem_ready);
    if (last) pkgs_sent++;
    @(posedge net_clk);
    #2 mem_valid = 1'b0;
  endtask

  task automatic wait_drain;
    while (exp_data_q.size() != 0 || exp_addr_q.size() != 0) @(negedge net_clk);
  endtask

  task automatic close_run;
    int prop_errs;
    prop_errs = DUT.stream_props.prop_fails;
    $display("errors: %0d mismatch, %0d other, %0d property", mism_errs, other_errs, prop_errs);
    if (mism_errs + other_errs + prop_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // read command monitor, values settle by the falling edge
  always @(negedge net_clk) begin
    if (net_aresetn) begin
      if (exp_cyc_q.size() != 0 && exp_cyc_q[0] == cyc) begin
        assert (mem_rd_valid) else begin
          other_errs++;
          $display("mem_rd_valid low at %0t ns, one cycle after a command was taken", $time);
        end
      end
      if (mem_rd_valid) begin
        assert (exp_addr_q.size() != 0) else begin
          other_errs++;
          $display("mem_rd_valid high at %0t ns with no command taken", $time);
        end
        if (exp_addr_q.size() != 0) begin
          assert (mem_rd_addr == exp_addr_q[0])
            else show_value_error("mem_rd_addr", exp_addr_q[0], mem_rd_addr);
          assert (mem_rd_len == exp_len_q[0])
            else show_value_error("mem_rd_len", exp_len_q[0], mem_rd_len);
          if (mem_rd_ready) begin
            void'(exp_addr_q.pop_front());
            void'(exp_len_q.pop_front());
            void'(exp_cyc_q.pop_front());
          end
        end
      end
      if (cmd_valid && cmd_ready) begin             // address 63:32, length 22:0
        exp_addr_q.push_back({32'h0, cmd_word.raw[63:32]});
        exp_len_q.push_back({9'h0, cmd_word.raw[22:0]});
        exp_cyc_q.push_back(cyc + 1);
      end
    end
  end

  // network word scoreboard
  always @(negedge net_clk) begin
    if (net_aresetn && net_valid && net_ready) begin
      assert (exp_data_q.size() != 0) else begin
        other_errs++;
        $display("extra network word at %0t ns, none expected", $time);
      end
      if (exp_data_q.size() != 0) begin
        assert (net_data == exp_data_q[0])
          else show_value_error("net_data", exp_data_q[0], net_data);
        assert (net_keep == exp_keep_q[0])
          else show_value_error("net_keep", exp_keep_q[0], net_keep);
        assert (net_last == exp_last_q[0])
          else show_value_error("net_last", exp_last_q[0], net_last);
        void'(exp_data_q.pop_front());
        void'(exp_keep_q.pop_front());
        void'(exp_last_q.pop_front());
      end
    end
  end

  initial begin
    repeat ($size(tab_keep) * 20 + 200) @(posedge net_clk);
    other_errs++;
    $display("timeout at %0t ns, traffic did not drain", $time);
    close_run();
  end

  initial begin
    repeat (8) @(posedge net_clk);
    #2 net_aresetn = 1'b1;
    @(negedge net_clk);
    assert (cmd_ready) else show_value_error("cmd_ready", 1, cmd_ready);
    assert (!mem_rd_valid) else show_value_error("mem_rd_valid", 0, mem_rd_valid);
    assert (!net_valid) else show_value_error("net_valid", 0, net_valid);
    assert (mem_ready) else show_value_error("mem_ready", 1, mem_ready);
    assert (read_cmd_count == 0) else show_value_error("read_cmd_count", 0, read_cmd_count);
    assert (read_pkg_count == 0) else show_value_error("read_pkg_count", 0, read_pkg_count);
    assert (tx_buffer_count == 0) else show_value_error("tx_buffer_count", 0, tx_buffer_count);
    @(posedge net_clk);
    #2;
    fork                                            // commands and beats in parallel
      for (int i = 0; i < $size(tab_cmd); i++) send_cmd(tab_cmd[i]);
      for (int i = 0; i < $size(tab_keep); i++) send_beat(tab_keep[i], tab_last[i], tab_seed[i]);
    join
    wait_drain();
    // stall the network port and overfill the fifo
    @(negedge net_clk);
    hold_net = 1'b1;
    @(posedge net_clk);
    #2;
    for (int i = 0; i < 5; i++) send_beat('1, i == 4, 64'hF000_0000_0000_0000 + i * 64'h10);
    repeat (3) @(posedge net_clk);
    @(negedge net_clk);
    assert (tx_buffer_count == ((exp_data_q.size() > 32) ? 32 : exp_data_q.size()))
      else show_value_error("tx_buffer_count", (exp_data_q.size() > 32) ? 32 : exp_data_q.size(),
                            tx_buffer_count);
    repeat (4) begin                                // held beat blocks new ones
      assert (!mem_ready) else show_value_error("mem_ready", 0, mem_ready);
      @(negedge net_clk);
    end
    hold_net = 1'b0;
    wait_drain();
    repeat (2) @(negedge net_clk);
    assert (read_cmd_count == cmds_sent)
      else show_value_error("read_cmd_count", cmds_sent, read_cmd_count);
    assert (read_pkg_count == pkgs_sent)
      else show_value_error("read_pkg_count", pkgs_sent, read_pkg_count);
    close_run();
  end

endmodule

`default_nettype wire

//--- tcp_tx_mem_path.f
hdl/tcp_mem_pkg.sv
hdl/mem_cmd_formatter.sv
hdl/mem_width_downsizer.sv
hdl/net_tx_fifo.sv
hdl/tcp_tx_mem_path.sv
test/tcp_tx_mem_path_props.sv
test/tcp_tx_mem_path_tb.sv
